// ==== include/meshData.svh ====
// world vertices in table order. They form a cube of side 200 around (200, 200, 200).
localparam worldVertexT meshWorld [numVertices] = '{
	'{12'd100, 12'd100, 12'd100},
	'{12'd300, 12'd100, 12'd100},
	'{12'd300, 12'd300, 12'd100},
	'{12'd100, 12'd300, 12'd100},
	'{12'd100, 12'd100, 12'd300},
	'{12'd300, 12'd100, 12'd300},
	'{12'd300, 12'd300, 12'd300},
	'{12'd100, 12'd300, 12'd300}
};

// Corner indices count from 1. The first corner sits in the top nibble ([2]).
localparam logic [2:0][3:0] meshFaces [numFaces] = '{
	12'h123, // front.
	12'h134,
	12'h567, // back.
	12'h578,
	12'h126, // bottom.
	12'h165,
	12'h437, // top.
	12'h478,
	12'h148, // left.
	12'h185,
	12'h237, // right.
	12'h276
};

// ==== logic/wirePkg.sv ====
package wirePkg;

	localparam int numVertices = 8; // cube corners.
	localparam int numFaces = 12; // two triangles per cube side.
	localparam int addrW = 5; // shared by both record memories.
	localparam int coordW = 12;
	localparam int scrW = 10;

	// the assembler spends a fixed number of cycles on every face.
	localparam int cyclesPerFace = 8;
	localparam int assembleCycles = numFaces * cyclesPerFace;

	// one vertex as it sits in the mesh table.
	typedef struct packed {
		logic [coordW-1:0] x;
		logic [coordW-1:0] y;
		logic [coordW-1:0] z;
	} worldVertexT;

	// one projected vertex; depth is not kept.
	typedef struct packed {
		logic [scrW-1:0] x;
		logic [scrW-1:0] y;
	} screenVertexT;

	// Corners appear in face order with c0 in the top bits.
	typedef struct packed {
		screenVertexT c0;
		screenVertexT c1;
		screenVertexT c2;
	} lineRecordT;

endpackage

// ==== logic/ramPort.sv ====
interface ramPort import wirePkg::*; #(
	parameter type payloadT = logic
) ();

	logic wrEn;
	logic [addrW-1:0] wrAddr;
	payloadT wrData;

	logic [addrW-1:0] rdAddr;
	payloadT rdData; // valid one edge after rdAddr.

	modport writer (
		output wrEn,
		output wrAddr,
		output wrData
	);

	modport reader (
		output rdAddr,
		input rdData
	);

	modport mem (
		input wrEn,
		input wrAddr,
		input wrData,
		input rdAddr,
		output rdData
	);

endinterface

// ==== logic/recordRam.sv ====
module recordRam import wirePkg::*; #(
	parameter type payloadT = logic
) (
	input logic iClk,
	ramPort.mem mem
);

	localparam int depth = 2 ** addrW;

	payloadT store [depth];

	always_ff @(posedge iClk) begin
		if (mem.wrEn) begin
			store[mem.wrAddr] <= mem.wrData;
		end
	end

	// a read of the address being written returns the old entry.
	always_ff @(posedge iClk) begin
		mem.rdData <= store[mem.rdAddr];
	end

endmodule

// ==== logic/vertexFetch.sv ====
module vertexFetch import wirePkg::*; (
	input logic iClk,
	input logic reset,
	input logic camMoved,
	input logic xfAck,
	input logic [scrW-1:0] scrX,
	input logic [scrW-1:0] scrY,
	output logic xfReq,
	output logic [coordW-1:0] worldX,
	output logic [coordW-1:0] worldY,
	output logic [coordW-1:0] worldZ,
	output logic verticesDone,
	ramPort.writer scr
);

	`include "meshData.svh"

	localparam int vtxW = $clog2(numVertices);
	localparam logic [vtxW-1:0] lastVertex = vtxW'(numVertices - 1);
	localparam int waitW = $clog2(assembleCycles + 1);
	localparam logic [waitW-1:0] waitLast = waitW'(assembleCycles);

	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stRelease,
		stDone
	} fetchStateT;

	fetchStateT state;
	logic [vtxW-1:0] vtxCnt;
	logic [waitW-1:0] waitCnt;
	worldVertexT curVertex;
	screenVertexT projected;

	// the counter only moves while xfReq is low, so the world bus is stable.
	assign curVertex = meshWorld[vtxCnt];
	assign worldX = curVertex.x;
	assign worldY = curVertex.y;
	assign worldZ = curVertex.z;

	assign projected.x = scrX;
	assign projected.y = scrY;

	// The store is written on the same edge that drops xfReq.
	assign scr.wrEn = xfReq & xfAck;
	assign scr.wrAddr = {{(addrW - vtxW){1'b0}}, vtxCnt};
	assign scr.wrData = projected;

	assign verticesDone = (state == stDone) && (waitCnt == '0); // first done cycle only.

	always_ff @(posedge iClk) begin
		if (reset) begin
			state <= stIdle;
			xfReq <= 1'b0;
			vtxCnt <= '0;
			waitCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (camMoved) begin
						vtxCnt <= '0;
						xfReq <= 1'b1;
						state <= stRequest;
					end
				end
				stRequest: begin
					if (xfAck) begin
						xfReq <= 1'b0; // screen vertex captured this edge.
						state <= stRelease;
					end
				end
				stRelease: begin
					// wait for the projection unit to drop its ack.
					if (!xfAck) begin
						if (vtxCnt == lastVertex) begin
							waitCnt <= '0;
							state <= stDone;
						end else begin
							vtxCnt <= vtxCnt + 1'b1;
							xfReq <= 1'b1;
							state <= stRequest;
						end
					end
				end
				stDone: begin
					// Stays here until the assembler raises ready, so a camMoved
					// during face assembly does not start a second fetch.
					waitCnt <= waitCnt + 1'b1;
					if (waitCnt == waitLast) begin
						state <= stIdle;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

endmodule

// ==== logic/faceAssemble.sv ====
module faceAssemble import wirePkg::*; (
	input logic iClk,
	input logic reset,
	input logic camMoved,
	input logic verticesDone,
	output logic ready,
	ramPort.reader scr,
	ramPort.writer disp
);

	`include "meshData.svh"

	localparam int phaseW = $clog2(cyclesPerFace);
	localparam logic [phaseW-1:0] writePhase = phaseW'(cyclesPerFace - 2);
	localparam logic [phaseW-1:0] lastPhase = phaseW'(cyclesPerFace - 1);
	localparam int faceW = $clog2(numFaces);
	localparam logic [faceW-1:0] lastFace = faceW'(numFaces - 1);

	logic busy;
	logic [faceW-1:0] faceCnt;
	logic [phaseW-1:0] phase;
	logic [1:0] cornerSel;
	logic [3:0] cornerIdx;
	logic [3:0] cornerAddr;
	lineRecordT record;

	// Phases 0 to 5 take two cycles per corner. Even is address, odd is capture.
	assign cornerSel = phase[phaseW-1:1];

	always_comb begin
		case (cornerSel)
			2'd0: cornerIdx = meshFaces[faceCnt][2];
			2'd1: cornerIdx = meshFaces[faceCnt][1];
			default: cornerIdx = meshFaces[faceCnt][0];
		endcase
	end

	assign cornerAddr = cornerIdx - 4'd1; // table indices count from 1.
	assign scr.rdAddr = {{(addrW - 4){1'b0}}, cornerAddr};

	assign disp.wrEn = busy && (phase == writePhase);
	assign disp.wrAddr = {{(addrW - faceW){1'b0}}, faceCnt};
	assign disp.wrData = record;

	// each corner is captured one cycle after its address went out.
	always_ff @(posedge iClk) begin
		if (busy && phase[0] && (phase < writePhase)) begin
			case (cornerSel)
				2'd0: record.c0 <= scr.rdData;
				2'd1: record.c1 <= scr.rdData;
				default: record.c2 <= scr.rdData;
			endcase
		end
	end

	always_ff @(posedge iClk) begin
		if (reset) begin
			busy <= 1'b0;
			ready <= 1'b0;
			faceCnt <= '0;
			phase <= '0;
		end else if (busy) begin
			phase <= phase + 1'b1; // wraps back to the first corner.
			if (phase == lastPhase) begin
				if (faceCnt == lastFace) begin
					faceCnt <= '0;
					busy <= 1'b0;
					ready <= 1'b1; // all twelve records are in place.
				end else begin
					faceCnt <= faceCnt + 1'b1;
				end
			end
		end else if (verticesDone) begin
			busy <= 1'b1;
			faceCnt <= '0;
			phase <= '0;
		end else if (camMoved && ready) begin
			ready <= 1'b0; // a new frame starts in the fetcher on this edge.
		end
	end

endmodule

// ==== logic/wireframeControl.sv ====
module wireframeControl import wirePkg::*; (
	input logic iClk,
	input logic reset,
	input logic camMoved,
	input logic xfAck,
	input logic [scrW-1:0] scrX,
	input logic [scrW-1:0] scrY,
	input logic [addrW-1:0] dispAddr,
	output logic xfReq,
	output logic [coordW-1:0] worldX,
	output logic [coordW-1:0] worldY,
	output logic [coordW-1:0] worldZ,
	output logic ready,
	output lineRecordT dispData
);

	logic verticesDone;

	ramPort #(.payloadT(screenVertexT)) scrPort ();
	ramPort #(.payloadT(lineRecordT)) dispPort ();

	// producer side. Talks to the projection unit and fills the screen store.
	vertexFetch fetch (
		.iClk(iClk),
		.reset(reset),
		.camMoved(camMoved),
		.xfAck(xfAck),
		.scrX(scrX),
		.scrY(scrY),
		.xfReq(xfReq),
		.worldX(worldX),
		.worldY(worldY),
		.worldZ(worldZ),
		.verticesDone(verticesDone),
		.scr(scrPort.writer)
	);

	recordRam #(.payloadT(screenVertexT)) scrRam (
		.iClk(iClk),
		.mem(scrPort.mem)
	);

	faceAssemble assemble (
		.iClk(iClk),
		.reset(reset),
		.camMoved(camMoved),
		.verticesDone(verticesDone),
		.ready(ready),
		.scr(scrPort.reader),
		.disp(dispPort.writer)
	);

	recordRam #(.payloadT(lineRecordT)) dispRam (
		.iClk(iClk),
		.mem(dispPort.mem)
	);

	// the line drawer owns the display read port.
	assign dispPort.rdAddr = dispAddr;
	assign dispData = dispPort.rdData;

endmodule

// ==== tb/tbWireframe.sv ====
module tbWireframe import wirePkg::*; ();

	`include "meshData.svh"

	localparam int cycleLimit = 4 * (numVertices * 14 + 110) + 200;

	logic iClk = 1'b0;
	logic reset = 1'b1;
	logic camMoved = 1'b0;
	logic xfAck = 1'b0;
	logic [scrW-1:0] scrX = '0;
	logic [scrW-1:0] scrY = '0;
	logic [addrW-1:0] dispAddr = '0;
	logic xfReq;
	logic [coordW-1:0] worldX;
	logic [coordW-1:0] worldY;
	logic [coordW-1:0] worldZ;
	logic ready;
	lineRecordT dispData;

	int errorCount = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	string curTest = "reset";

	int frameOffset = 0;
	int delays [numVertices];
	int jitters [numVertices];
	int hsCount = 0; // handshakes completed in the current frame.
	int waitLeft = -1;
	int vtxIdx = 0;
	screenVertexT sent;
	screenVertexT recorded [numVertices];

	wireframeControl DUT (
		.iClk(iClk),
		.reset(reset),
		.camMoved(camMoved),
		.xfAck(xfAck),
		.scrX(scrX),
		.scrY(scrY),
		.dispAddr(dispAddr),
		.xfReq(xfReq),
		.worldX(worldX),
		.worldY(worldY),
		.worldZ(worldZ),
		.ready(ready),
		.dispData(dispData)
	);

	always #2 iClk = ~iClk;

	always @(posedge iClk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles.", cycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic compareValue(input string testName, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	// the projection unit model also checks the world bus.
	always @(posedge iClk) begin
		if (reset) begin
			xfAck <= 1'b0;
			waitLeft = -1;
		end else begin
			if (xfReq && hsCount < numVertices) begin
				compareValue({curTest, " world vertex"}, meshWorld[hsCount],
					{worldX, worldY, worldZ});
			end
			if (xfAck) begin
				if (!xfReq) begin
					xfAck <= 1'b0;
					hsCount++; // handshake is complete once ack is back low.
				end
			end else if (xfReq) begin
				vtxIdx = hsCount % numVertices;
				if (waitLeft < 0) begin
					waitLeft = delays[vtxIdx];
				end
				if (waitLeft == 0) begin
					sent.x = scrW'(worldX + frameOffset + jitters[vtxIdx]);
					sent.y = scrW'(worldY + frameOffset);
					if (hsCount < numVertices) begin
						recorded[hsCount] = sent;
					end
					scrX <= sent.x;
					scrY <= sent.y;
					xfAck <= 1'b1;
					waitLeft = -1;
				end else begin
					waitLeft--;
				end
			end
		end
	end

	// corners are taken in face order with the first corner from the top nibble.
	function automatic lineRecordT expectedRecord(input int face);
		lineRecordT rec;
		rec.c0 = recorded[meshFaces[face][2] - 1];
		rec.c1 = recorded[meshFaces[face][1] - 1];
		rec.c2 = recorded[meshFaces[face][0] - 1];
		return rec;
	endfunction

	task automatic startTest(input string name);
		curTest = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errorCount == testErrors) begin
			$display("%s: ok", curTest);
		end else begin
			testsFailed++;
			$display("%s: %0d mismatches", curTest, errorCount - testErrors);
		end
	endtask

	task automatic prepareFrame();
		frameOffset = $urandom_range(1023, 0);
		for (int i = 0; i < numVertices; i++) begin
			delays[i] = $urandom_range(5, 0);
			jitters[i] = $urandom_range(15, 0);
		end
		hsCount = 0;
	endtask

	task automatic pulseCamMoved();
		@(posedge iClk);
		camMoved <= 1'b1;
		@(posedge iClk);
		camMoved <= 1'b0;
	endtask

	task automatic waitReady();
		while (!ready) begin
			@(posedge iClk);
		end
	endtask

	// dispData holds the entry one edge after dispAddr is taken.
	task automatic checkDisplay();
		for (int f = 0; f < numFaces; f++) begin
			@(posedge iClk);
			dispAddr <= addrW'(f);
			@(posedge iClk);
			@(posedge iClk);
			compareValue($sformatf("%s face %0d", curTest, f), expectedRecord(f), dispData);
		end
	endtask

	initial begin
		void'($urandom(32'h8a02_4760));
		repeat (5) @(posedge iClk);
		reset <= 1'b0;

		startTest("afterReset");
		repeat (10) begin
			@(posedge iClk);
			compareValue({curTest, " xfReq"}, 0, xfReq);
			compareValue({curTest, " ready"}, 0, ready);
		end
		endTest();

		startTest("oneFrame");
		prepareFrame();
		pulseCamMoved();
		waitReady();
		compareValue({curTest, " handshakes"}, numVertices, hsCount);
		endTest();

		startTest("displayContents");
		checkDisplay();
		endTest();

		startTest("secondFrame");
		compareValue({curTest, " ready before"}, 1, ready);
		prepareFrame();
		pulseCamMoved();
		@(posedge iClk);
		compareValue({curTest, " ready drop"}, 0, ready);
		compareValue({curTest, " xfReq rise"}, 1, xfReq);
		waitReady();
		compareValue({curTest, " handshakes"}, numVertices, hsCount);
		checkDisplay();
		endTest();

		startTest("busyFrame");
		prepareFrame();
		pulseCamMoved();
		while (hsCount < numVertices) begin
			@(posedge iClk);
			camMoved <= ($urandom_range(3, 0) == 0);
		end
		@(posedge iClk);
		camMoved <= 1'b0;
		repeat (20) @(posedge iClk); // well inside face assembly.
		camMoved <= 1'b1;
		@(posedge iClk);
		camMoved <= 1'b0;
		waitReady();
		repeat (5) @(posedge iClk);
		compareValue({curTest, " ready held"}, 1, ready);
		compareValue({curTest, " xfReq idle"}, 0, xfReq);
		compareValue({curTest, " handshakes"}, numVertices, hsCount);
		checkDisplay();
		endTest();

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
logic/wirePkg.sv
logic/ramPort.sv
logic/recordRam.sv
logic/vertexFetch.sv
logic/faceAssemble.sv
logic/wireframeControl.sv
tb/tbWireframe.sv

// ==== Bender.yml ====
package:
  name: wireframe_control

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wirePkg.sv
      - logic/ramPort.sv
      - logic/recordRam.sv
      - logic/vertexFetch.sv
      - logic/faceAssemble.sv
      - logic/wireframeControl.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tbWireframe.sv
